/* source/proc_pkg.sv */
/*
  Shared widths, instruction field codes and control encodings for the
  three-stage pipelined core and its testbench model.
*/
package proc_pkg;

  // --------------------------------------------------------------------------
  // Word and field types
  // --------------------------------------------------------------------------

  typedef logic [31:0] data_t;      // Machine word
  typedef logic [31:0] inst_t;      // Instruction word
  typedef logic [4:0]  reg_addr_t;  // Register specifier
  typedef logic [4:0]  shamt_t;     // Shift amount field
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  func_t;

  localparam int num_regs = 32;

  // --------------------------------------------------------------------------
  // Opcodes
  // --------------------------------------------------------------------------

  localparam opcode_t op_special = 6'b000000;  // R-type, function in func field
  localparam opcode_t op_addiu   = 6'b001001;
  localparam opcode_t op_ori     = 6'b001101;
  localparam opcode_t op_lui     = 6'b001111;
  localparam opcode_t op_cop0    = 6'b010000;  // mfc0 and mtc0

  // R-type function codes
  localparam func_t fn_sll  = 6'b000000;
  localparam func_t fn_srl  = 6'b000010;
  localparam func_t fn_addu = 6'b100001;
  localparam func_t fn_subu = 6'b100011;
  localparam func_t fn_and  = 6'b100100;
  localparam func_t fn_or   = 6'b100101;
  localparam func_t fn_xor  = 6'b100110;
  localparam func_t fn_nor  = 6'b100111;
  localparam func_t fn_sltu = 6'b101011;

  // Coprocessor 0 sub-codes, found in the rs field
  localparam reg_addr_t cp0_mf = 5'b00000;
  localparam reg_addr_t cp0_mt = 5'b00100;

  // --------------------------------------------------------------------------
  // Control encodings
  // --------------------------------------------------------------------------

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_nor,
    alu_sll,
    alu_srl,
    alu_ltu,
    alu_lui,
    alu_cp1    // Pass operand 1 through
  } alu_fn_e;

  typedef enum logic {
    op0_shamt,  // Shift amount field
    op0_rs      // Register rs
  } op0_sel_e;

  typedef enum logic [1:0] {
    op1_rt,     // Register rt
    op1_si,     // Sign-extended immediate
    op1_zi,     // Zero-extended immediate
    op1_mngr    // Data from the manager
  } op1_sel_e;

endpackage

/* source/proc_stage_if.sv */
/*
  Stage-to-stage bundles. dx_if runs from decode to execute, xw_if from
  execute to result; each carries a stall back toward the earlier stage.
*/
interface dx_if;
  import proc_pkg::*;

  logic      val;
  alu_fn_e   alu_fn;
  data_t     op0;
  data_t     op1;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  logic      to_mngr;   // Entry is an mtc0
  logic      stall;     // Execute cannot take a new entry

  modport decode_out (
    output val, alu_fn, op0, op1, rf_wen, rf_waddr, to_mngr,
    input  stall
  );

  modport execute_in (
    input  val, alu_fn, op0, op1, rf_wen, rf_waddr, to_mngr,
    output stall
  );
endinterface

interface xw_if;
  import proc_pkg::*;

  logic      val;
  data_t     result;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  logic      to_mngr;
  logic      stall;     // Result stage is holding

  modport execute_out (output val, result, rf_wen, rf_waddr, to_mngr, input stall);
  modport result_in   (input val, result, rf_wen, rf_waddr, to_mngr, output stall);

  // Decode looks at X's destination for hazard checks
  modport monitor (input val, rf_wen, rf_waddr);
endinterface

/* source/proc_regfile.sv */
/*
  General purpose registers: two combinational read ports and one write
  port that takes effect on the clock edge. Register 0 always reads zero.
*/
module proc_regfile (
  input  logic                clk,
  input  logic                wen,
  input  proc_pkg::reg_addr_t waddr,
  input  proc_pkg::data_t     wdata,
  input  proc_pkg::reg_addr_t raddr0,
  output proc_pkg::data_t     rdata0,
  input  proc_pkg::reg_addr_t raddr1,
  output proc_pkg::data_t     rdata1
);
  import proc_pkg::*;

  data_t regs [0:num_regs-1];

  // Writes to register 0 are dropped
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  always_comb begin
    if (raddr0 == '0) begin
      rdata0 = '0;
    end else begin
      rdata0 = regs[raddr0];
    end
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

endmodule

/* source/proc_decode.sv */
/*
  D stage: holds the accepted instruction, decodes it, reads operands and
  sends either the instruction or a bubble to execute.
*/
module proc_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                inst_val,
  output logic                inst_rdy,
  input  proc_pkg::inst_t     inst,
  input  logic                from_mngr_val,
  output logic                from_mngr_rdy,
  input  proc_pkg::data_t     from_mngr_data,
  dx_if.decode_out            dx,
  xw_if.monitor               xw,
  input  logic                w_wen,
  input  proc_pkg::reg_addr_t w_waddr,
  input  proc_pkg::data_t     w_wdata
);
  import proc_pkg::*;

  logic      val_d;
  inst_t     inst_d;
  opcode_t   opcode;
  reg_addr_t rs, rt, rd;
  shamt_t    shamt;
  func_t     func;
  data_t     rdata0, rdata1;

  op0_sel_e  op0_sel;
  op1_sel_e  op1_sel;
  alu_fn_e   alu_fn;
  logic      rs_en, rt_en;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  logic      is_mfc0, is_mtc0;

  logic      rs_hazard, rt_hazard;
  logic      stall_d;
  logic      leave_d;   // D's instruction moves to X this cycle

  // --------------------------------------------------------------------------
  // Instruction register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (inst_rdy) begin
      val_d <= inst_val;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_val && inst_rdy) begin
      inst_d <= inst;
    end
  end

  assign opcode = inst_d[31:26];
  assign rs     = inst_d[25:21];
  assign rt     = inst_d[20:16];
  assign rd     = inst_d[15:11];
  assign shamt  = inst_d[10:6];
  assign func   = inst_d[5:0];

  // --------------------------------------------------------------------------
  // Decode table
  // --------------------------------------------------------------------------

  // All-zero nop is sll into r0, which writes nothing
  always_comb begin
    op0_sel  = op0_rs;
    op1_sel  = op1_rt;
    alu_fn   = alu_cp1;
    rs_en    = 1'b0;
    rt_en    = 1'b0;
    rf_wen   = 1'b0;
    rf_waddr = rd;
    is_mfc0  = 1'b0;
    is_mtc0  = 1'b0;
    case (opcode)
      op_special: begin
        rs_en  = 1'b1;
        rt_en  = 1'b1;
        rf_wen = 1'b1;
        case (func)
          fn_addu: alu_fn = alu_add;
          fn_subu: alu_fn = alu_sub;
          fn_and:  alu_fn = alu_and;
          fn_or:   alu_fn = alu_or;
          fn_xor:  alu_fn = alu_xor;
          fn_nor:  alu_fn = alu_nor;
          fn_sltu: alu_fn = alu_ltu;
          fn_sll, fn_srl: begin
            op0_sel = op0_shamt;
            rs_en   = 1'b0;
            alu_fn  = (func == fn_sll) ? alu_sll : alu_srl;
          end
          default: begin          // Unknown function, behaves as nop
            rs_en  = 1'b0;
            rt_en  = 1'b0;
            rf_wen = 1'b0;
          end
        endcase
      end
      op_addiu, op_ori: begin
        rs_en    = 1'b1;
        rf_wen   = 1'b1;
        rf_waddr = rt;
        op1_sel  = (opcode == op_addiu) ? op1_si : op1_zi;
        alu_fn   = (opcode == op_addiu) ? alu_add : alu_or;
      end
      op_lui: begin
        rf_wen   = 1'b1;
        rf_waddr = rt;
        op1_sel  = op1_zi;
        alu_fn   = alu_lui;
      end
      op_cop0: begin
        if (rs == cp0_mf) begin   // rt <- manager data
          is_mfc0  = 1'b1;
          rf_wen   = 1'b1;
          rf_waddr = rt;
          op1_sel  = op1_mngr;
        end else if (rs == cp0_mt) begin
          is_mtc0 = 1'b1;
          rt_en   = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // --------------------------------------------------------------------------
  // Register read and operands
  // --------------------------------------------------------------------------

  proc_regfile regfile (
    .clk    (clk),
    .wen    (w_wen),
    .waddr  (w_waddr),
    .wdata  (w_wdata),
    .raddr0 (rs),
    .rdata0 (rdata0),
    .raddr1 (rt),
    .rdata1 (rdata1)
  );

  always_comb begin
    case (op0_sel)
      op0_shamt: dx.op0 = {27'b0, shamt};
      default:   dx.op0 = rdata0;
    endcase
    case (op1_sel)
      op1_si:   dx.op1 = {{16{inst_d[15]}}, inst_d[15:0]};
      op1_zi:   dx.op1 = {16'b0, inst_d[15:0]};
      op1_mngr: dx.op1 = from_mngr_data;
      default:  dx.op1 = rdata1;
    endcase
  end

  // --------------------------------------------------------------------------
  // Stalls and handshakes
  // --------------------------------------------------------------------------

  // No bypassing, so wait until the writer in X or W has retired
  assign rs_hazard = rs_en && (rs != '0) &&
                     ((xw.val && xw.rf_wen && (xw.rf_waddr == rs)) ||
                      (w_wen && (w_waddr == rs)));
  assign rt_hazard = rt_en && (rt != '0) &&
                     ((xw.val && xw.rf_wen && (xw.rf_waddr == rt)) ||
                      (w_wen && (w_waddr == rt)));

  assign stall_d = rs_hazard || rt_hazard || (is_mfc0 && !from_mngr_val);
  assign leave_d = val_d && !stall_d && !dx.stall;

  assign inst_rdy      = !val_d || leave_d;
  assign from_mngr_rdy = leave_d && is_mfc0;

  assign dx.val      = val_d && !stall_d;   // Bubble while stalled
  assign dx.alu_fn   = alu_fn;
  assign dx.rf_wen   = rf_wen;
  assign dx.rf_waddr = rf_waddr;
  assign dx.to_mngr  = is_mtc0;

endmodule

/* source/proc_execute.sv */
/*
  X stage: registers decode's output and runs the ALU on the registered
  operands. Holds whenever the result stage holds.
*/
module proc_execute (
  input  logic      clk,
  input  logic      reset,
  dx_if.execute_in  dx,
  xw_if.execute_out xw
);
  import proc_pkg::*;

  logic      val_x;
  alu_fn_e   alu_fn_x;
  data_t     op0_x, op1_x;
  logic      rf_wen_x;
  reg_addr_t rf_waddr_x;
  logic      to_mngr_x;
  data_t     alu_out;

  assign dx.stall = xw.stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (!xw.stall) begin
      val_x <= dx.val;    // Takes a bubble when decode has nothing
    end
  end

  always_ff @(posedge clk) begin
    if (!xw.stall) begin
      alu_fn_x   <= dx.alu_fn;
      op0_x      <= dx.op0;
      op1_x      <= dx.op1;
      rf_wen_x   <= dx.rf_wen;
      rf_waddr_x <= dx.rf_waddr;
      to_mngr_x  <= dx.to_mngr;
    end
  end

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------

  always_comb begin
    case (alu_fn_x)
      alu_add: alu_out = op0_x + op1_x;
      alu_sub: alu_out = op0_x - op1_x;
      alu_and: alu_out = op0_x & op1_x;
      alu_or:  alu_out = op0_x | op1_x;
      alu_xor: alu_out = op0_x ^ op1_x;
      alu_nor: alu_out = ~(op0_x | op1_x);
      alu_sll: alu_out = op1_x << op0_x[4:0];   // Shift amount in operand 0
      alu_srl: alu_out = op1_x >> op0_x[4:0];
      alu_ltu: alu_out = {31'b0, op0_x < op1_x};
      alu_lui: alu_out = {op1_x[15:0], 16'b0};
      default: alu_out = op1_x;                 // cp1
    endcase
  end

  assign xw.val      = val_x;
  assign xw.result   = alu_out;
  assign xw.rf_wen   = rf_wen_x;
  assign xw.rf_waddr = rf_waddr_x;
  assign xw.to_mngr  = to_mngr_x;

endmodule

/* source/proc_result.sv */
/*
  W stage: writes ALU results back to the register file and hands mtc0
  values to the manager, holding the pipeline until they are taken.
*/
module proc_result (
  input  logic                clk,
  input  logic                reset,
  xw_if.result_in             xw,
  output logic                to_mngr_val,
  input  logic                to_mngr_rdy,
  output proc_pkg::data_t     to_mngr_data,
  output logic                w_wen,
  output proc_pkg::reg_addr_t w_waddr,
  output proc_pkg::data_t     w_wdata
);
  import proc_pkg::*;

  logic      val_w;
  data_t     result_w;
  logic      rf_wen_w;
  reg_addr_t rf_waddr_w;
  logic      to_mngr_w;
  logic      stall_w;

  // Manager not ready for an mtc0
  assign stall_w  = val_w && to_mngr_w && !to_mngr_rdy;
  assign xw.stall = stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (!stall_w) begin
      val_w <= xw.val;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_w) begin
      result_w   <= xw.result;
      rf_wen_w   <= xw.rf_wen;
      rf_waddr_w <= xw.rf_waddr;
      to_mngr_w  <= xw.to_mngr;
    end
  end

  assign to_mngr_val  = val_w && to_mngr_w;
  assign to_mngr_data = result_w;

  assign w_wen   = val_w && rf_wen_w;   // Qualified by the W valid bit
  assign w_waddr = rf_waddr_w;
  assign w_wdata = result_w;

endmodule

/* source/proc_top.sv */
/*
  Core top level. Connects decode, execute and result; the instruction
  stream and both manager streams are plain valid/ready ports.
*/
module proc_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_val,
  output logic            inst_rdy,
  input  proc_pkg::inst_t inst,
  input  logic            from_mngr_val,
  output logic            from_mngr_rdy,
  input  proc_pkg::data_t from_mngr_data,
  output logic            to_mngr_val,
  input  logic            to_mngr_rdy,
  output proc_pkg::data_t to_mngr_data
);
  import proc_pkg::*;

  dx_if dx ();
  xw_if xw ();

  // Write-back path from W into the register file
  logic      w_wen;
  reg_addr_t w_waddr;
  data_t     w_wdata;

  proc_decode decode (
    .clk            (clk),
    .reset          (reset),
    .inst_val       (inst_val),
    .inst_rdy       (inst_rdy),
    .inst           (inst),
    .from_mngr_val  (from_mngr_val),
    .from_mngr_rdy  (from_mngr_rdy),
    .from_mngr_data (from_mngr_data),
    .dx             (dx.decode_out),
    .xw             (xw.monitor),
    .w_wen          (w_wen),
    .w_waddr        (w_waddr),
    .w_wdata        (w_wdata)
  );

  proc_execute execute (.clk(clk), .reset(reset), .dx(dx.execute_in), .xw(xw.execute_out));

  proc_result result (
    .clk          (clk),
    .reset        (reset),
    .xw           (xw.result_in),
    .to_mngr_val  (to_mngr_val),
    .to_mngr_rdy  (to_mngr_rdy),
    .to_mngr_data (to_mngr_data),
    .w_wen        (w_wen),
    .w_waddr      (w_waddr),
    .w_wdata      (w_wdata)
  );

endmodule

/* dv/proc_checker.sv */
/*
  Concurrent checks on the core's top-level handshakes, bound into
  proc_top by the testbench.
*/
module proc_checker (
  input logic            clk,
  input logic            reset,
  input logic            inst_rdy,
  input logic            from_mngr_rdy,
  input logic            to_mngr_val,
  input logic            to_mngr_rdy,
  input proc_pkg::data_t to_mngr_data
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failures;

  initial failures = 0;

  // Manager output holds until it is taken
  to_mngr_hold: assert property (@(posedge clk) disable iff (reset)
    to_mngr_val && !to_mngr_rdy |=> to_mngr_val && $stable(to_mngr_data))
  else begin
    failures++;
    $error("to_mngr output changed while to_mngr_rdy was low");
  end

  reset_idle: assert property (@(posedge clk)
    reset |=> !to_mngr_val && !from_mngr_rdy)
  else begin
    failures++;
    $error("Manager handshakes active during or right after reset");
  end

  // Data only has to be known while it is offered
  known_outputs: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({inst_rdy, from_mngr_rdy, to_mngr_val}) &&
    (!to_mngr_val || !$isunknown(to_mngr_data)))
  else begin
    failures++;
    $error("Unknown value on a top-level output");
  end

endmodule

/* dv/proc_tb.sv */
/*
  Testbench for the pipelined core: a random program runs against an
  in-order ISA model, with random stream gaps and manager back-pressure.
*/
module proc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import proc_pkg::*;

  localparam int prog_len   = 400;
  localparam int idle_limit = 1000;   // Cycles without any handshake

  logic  clk, reset;
  logic  inst_val, inst_rdy;
  inst_t inst;
  logic  from_mngr_val, from_mngr_rdy;
  data_t from_mngr_data;
  logic  to_mngr_val, to_mngr_rdy;
  data_t to_mngr_data;

  int    seed;
  inst_t prog [0:prog_len-1];
  data_t mngr_vals [0:prog_len-1];    // Manager data, sent in this order
  data_t model_regs [0:num_regs-1];
  data_t expected [$];                // mtc0 values still to come
  int    pc, mngr_sent, mfc0_used, mfc0_total, mtc0_total, received;
  int    checks, value_errors, other_errors, idle, tail;
  logic  inst_acc, mngr_acc, out_acc;

  proc_top UUT (.*);

  bind proc_top proc_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int unsigned rnd(input int unsigned range);
    return $unsigned($random(seed)) % range;
  endfunction

  // --------------------------------------------------------------------------
  // Program and manager data
  // --------------------------------------------------------------------------

  // Starts by loading r0..r7 from the manager, ends by sending them all back
  task automatic build_program();
    func_t       r_fns [0:8];
    reg_addr_t   rs, rt, rd;
    logic [15:0] imm;
    int unsigned kind;
    r_fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_sltu, fn_sll, fn_srl};
    for (int i = 0; i < prog_len; i++) begin
      rs   = reg_addr_t'(rnd(8));
      rt   = reg_addr_t'(rnd(8));
      rd   = reg_addr_t'(rnd(8));
      imm  = 16'($random(seed));
      kind = rnd(16);
      if (i < 8) begin
        kind = 12;
        rt   = reg_addr_t'(i);
      end else if (i >= prog_len - 8) begin
        kind = 14;
        rt   = reg_addr_t'(i - (prog_len - 8));
      end
      case (kind)
        0, 1, 2, 3, 4, 5, 6: prog[i] = {op_special, rs, rt, rd, 5'b0, r_fns[kind]};
        7, 8:    prog[i] = {op_special, 5'b0, rt, rd, imm[4:0], r_fns[kind]};
        9:       prog[i] = {op_addiu, rs, rt, imm};
        10:      prog[i] = {op_ori, rs, rt, imm};
        11:      prog[i] = {op_lui, 5'b0, rt, imm};
        12: begin
          prog[i] = {op_cop0, cp0_mf, rt, 16'b0};
          mfc0_total++;
        end
        13:      prog[i] = '0;   // nop
        default: begin
          prog[i] = {op_cop0, cp0_mt, rt, 16'b0};
          mtc0_total++;
        end
      endcase
      mngr_vals[i] = $random(seed);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model, one instruction per call in program order
  // --------------------------------------------------------------------------

  task automatic model_issue(input inst_t i);
    reg_addr_t rs, rt, dst;
    data_t     a, b, r;
    logic      wr;
    rs  = i[25:21];
    rt  = i[20:16];
    dst = i[15:11];
    a   = model_regs[rs];
    b   = model_regs[rt];
    r   = '0;
    wr  = 1'b0;
    case (i[31:26])
      op_special: begin
        wr = 1'b1;
        case (i[5:0])
          fn_addu: r = a + b;
          fn_subu: r = a - b;
          fn_and:  r = a & b;
          fn_or:   r = a | b;
          fn_xor:  r = a ^ b;
          fn_nor:  r = ~(a | b);
          fn_sltu: r = (a < b) ? 32'd1 : 32'd0;
          fn_sll:  r = b << i[10:6];
          fn_srl:  r = b >> i[10:6];
          default: wr = 1'b0;
        endcase
      end
      op_addiu: begin
        wr  = 1'b1;
        dst = rt;
        r   = a + {{16{i[15]}}, i[15:0]};
      end
      op_ori: begin
        wr  = 1'b1;
        dst = rt;
        r   = a | {16'b0, i[15:0]};
      end
      op_lui: begin
        wr  = 1'b1;
        dst = rt;
        r   = {i[15:0], 16'b0};
      end
      op_cop0: begin
        if (rs == cp0_mf) begin
          wr  = 1'b1;
          dst = rt;
          r   = mngr_vals[mfc0_used];
          mfc0_used++;
        end else if (rs == cp0_mt) begin
          expected.push_back(b);
        end
      end
      default: ;
    endcase
    if (wr && dst != '0) begin   // r0 stays zero
      model_regs[dst] = r;
    end
  endtask

  task automatic check_output();
    data_t want;
    received++;
    assert (expected.size() > 0) else begin
      other_errors++;
      $display("Manager output %h at %0t ns with no mtc0 pending", to_mngr_data, $time);
    end
    if (expected.size() > 0) begin
      want = expected.pop_front();
      checks++;
      assert (to_mngr_data === want) else begin
        value_errors++;
        $display("Fail at %0t ns: mtc0 sent %h, model expects %h", $time, to_mngr_data, want);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------------------------------

  initial begin
    seed           = 56;
    reset          = 1'b1;
    inst_val       = 1'b0;
    inst           = '0;
    from_mngr_val  = 1'b0;
    from_mngr_data = '0;
    to_mngr_rdy    = 1'b0;
    {pc, mngr_sent, mfc0_used, mfc0_total, mtc0_total, received} = '0;
    {checks, value_errors, other_errors, idle, tail} = '0;
    foreach (model_regs[k]) model_regs[k] = '0;
    build_program();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    assert (to_mngr_val === 1'b0 && from_mngr_rdy === 1'b0 && inst_rdy === 1'b1) else begin
      other_errors++;
      $display("Handshake outputs not idle after reset");
    end
    // Run until the program has drained, plus a few quiet cycles
    while (tail < 10 && idle < idle_limit) begin
      @(posedge clk);
      inst_acc = inst_val && inst_rdy;
      mngr_acc = from_mngr_val && from_mngr_rdy;
      out_acc  = to_mngr_val && to_mngr_rdy;
      if (inst_acc) begin
        model_issue(inst);
        pc++;
      end
      if (mngr_acc) mngr_sent++;
      if (out_acc) check_output();
      idle = (inst_acc || mngr_acc || out_acc) ? 0 : idle + 1;
      @(negedge clk);
      if (inst_acc || !inst_val) begin
        if (pc < prog_len && rnd(4) != 0) begin
          inst_val = 1'b1;
          inst     = prog[pc];
        end else begin
          inst_val = 1'b0;
        end
      end
      if (mngr_acc || !from_mngr_val) begin
        if (mngr_sent < mfc0_total && rnd(4) != 0) begin
          from_mngr_val  = 1'b1;
          from_mngr_data = mngr_vals[mngr_sent];
        end else begin
          from_mngr_val = 1'b0;
        end
      end
      to_mngr_rdy = (rnd(3) != 0);
      if (pc == prog_len && expected.size() == 0) tail++;
    end
    if (idle >= idle_limit) begin
      other_errors++;
      $display("Timeout: no handshake for %0d cycles, %0d of %0d instructions issued",
               idle_limit, pc, prog_len);
    end
    assert (received == mtc0_total) else begin
      other_errors++;
      $display("Got %0d manager outputs for %0d mtc0 instructions", received, mtc0_total);
    end
    assert (mngr_sent == mfc0_total) else begin
      other_errors++;
      $display("Core took %0d manager values for %0d mfc0 instructions", mngr_sent, mfc0_total);
    end
    other_errors += UUT.checker_i.failures;
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* src.f */
source/proc_pkg.sv
source/proc_stage_if.sv
source/proc_regfile.sv
source/proc_decode.sv
source/proc_execute.sv
source/proc_result.sv
source/proc_top.sv
dv/proc_checker.sv
dv/proc_tb.sv
